/* rtl/adc_pkg.sv */
`default_nettype none

package adc_pkg;

	// ==================================================
	// Defaults shared by both converter channels
	// ==================================================

	// Largest sync offset the aligner can correct, in clocks
	localparam int DEFAULT_MAX_DELAY = 7;

	// Width of a delay setting for the default range
	localparam int DELAY_W = $clog2(DEFAULT_MAX_DELAY + 1);

	// ==================================================
	// Converter and user word types
	// ==================================================

	// One clock of converter output, an even/odd pair for I and Q
	typedef struct packed {
		logic [7:0] even_i;
		logic [7:0] odd_i;
		logic [7:0] even_q;
		logic [7:0] odd_q;
		logic       sync;
		// Bit 0 flags the even sample, bit 1 the odd sample
		logic [1:0] outofrange;
	} adc_raw_t;

	// Four-sample user word, sample 0 is the oldest
	typedef struct packed {
		logic [3:0][7:0] datai;
		logic [3:0][7:0] dataq;
		// Word began on a sync pair
		logic            sync;
		logic [3:0]      outofrange;
		logic            valid;
	} adc_word_t;

	// Sync alignment FSM
	typedef enum logic [1:0] {
		IDLE,
		MEASURE,
		DONE,
		ERROR
	} align_state_e;

endpackage

`default_nettype wire

/* rtl/adc_delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_delay_line import adc_pkg::*; #(
	parameter int MAX_DELAY = DEFAULT_MAX_DELAY,
	parameter int DLY_W     = DELAY_W
) (
	input  logic             adc_clk,
	input  logic             rst_n,
	input  logic [DLY_W-1:0] delay,
	input  adc_raw_t         din,
	output adc_raw_t         dout
);

	// Tap n holds the pair that entered n+1 clocks ago
	adc_raw_t taps [MAX_DELAY+1];

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i <= MAX_DELAY; i++) begin
				taps[i] <= '0;
			end
		end else begin
			taps[0] <= din;
			for (int i = 1; i <= MAX_DELAY; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// Tap select, settings past the end use the last tap
	always_comb begin
		if (int'(delay) > MAX_DELAY) begin
			dout = taps[MAX_DELAY];
		end else begin
			dout = taps[delay];
		end
	end

endmodule

`default_nettype wire

/* rtl/adc_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_capture import adc_pkg::*; (
	input  logic      adc_clk,
	input  logic      rst_n,
	input  logic      enable,
	input  adc_raw_t  raw,
	output adc_word_t word,
	output logic      user_sync,
	output logic      user_outofrange
);

	// Which half of a word the next pair is
	typedef enum logic [1:0] {
		CAP_HUNT,
		CAP_FIRST,
		CAP_SECOND
	} cap_phase_e;

	cap_phase_e      phase;
	adc_raw_t        raw_q;
	adc_raw_t        first_q;
	logic            take_first;
	logic            take_second;
	logic [3:0][7:0] datai_q;
	logic [3:0][7:0] dataq_q;
	logic            sync_q;
	logic [3:0]      oor_q;
	logic            valid_q;

	// ==================================================
	// Input register and framing
	// ==================================================

	always_ff @(posedge adc_clk) begin
		raw_q <= raw;
	end

	// A sync pair always opens a word
	assign take_first  = enable && (raw_q.sync || phase == CAP_FIRST);
	assign take_second = enable && !raw_q.sync && phase == CAP_SECOND;

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			phase   <= CAP_HUNT;
			valid_q <= 1'b0;
		end else begin
			valid_q <= take_second;
			if (!enable) begin
				phase <= CAP_HUNT;
			end else if (take_first) begin
				phase <= CAP_SECOND;
			end else if (take_second) begin
				phase <= CAP_FIRST;
			end
		end
	end

	// ==================================================
	// Word packing
	// ==================================================

	always_ff @(posedge adc_clk) begin
		if (take_first) begin
			first_q <= raw_q;
		end
		if (take_second) begin
			// Oldest sample in index 0
			datai_q <= {raw_q.odd_i, raw_q.even_i, first_q.odd_i, first_q.even_i};
			dataq_q <= {raw_q.odd_q, raw_q.even_q, first_q.odd_q, first_q.even_q};
			sync_q  <= first_q.sync;
			oor_q   <= {raw_q.outofrange, first_q.outofrange};
			// Summary flags for the user side
			user_sync       <= first_q.sync;
			user_outofrange <= |{raw_q.outofrange, first_q.outofrange};
		end
	end

	// Valid drops as soon as alignment is lost
	assign word = '{
		datai:      datai_q,
		dataq:      dataq_q,
		sync:       sync_q,
		outofrange: oor_q,
		valid:      valid_q && enable
	};

endmodule

`default_nettype wire

/* rtl/adc_align_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_align_fsm import adc_pkg::*; #(
	parameter int MAX_DELAY = DEFAULT_MAX_DELAY,
	parameter int DLY_W     = DELAY_W
) (
	input  logic             adc_clk,
	input  logic             rst_n,
	input  logic             resync,
	input  logic             sync0,
	input  logic             sync1,
	output logic [DLY_W-1:0] delay0,
	output logic [DLY_W-1:0] delay1,
	output logic             sync_done,
	output logic             sync_error
);

	align_state_e     state;
	logic [DLY_W-1:0] cnt;
	// Converter 1 saw its sync first
	logic             sync1_first;
	logic             other_sync;

	assign other_sync = sync1_first ? sync0 : sync1;

	// ==================================================
	// Offset measurement
	// ==================================================

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			cnt         <= '0;
			sync1_first <= 1'b0;
			delay0      <= '0;
			delay1      <= '0;
		end else if (resync) begin
			state  <= IDLE;
			cnt    <= '0;
			delay0 <= '0;
			delay1 <= '0;
		end else begin
			unique case (state)
				IDLE: begin
					cnt         <= DLY_W'(1);
					sync1_first <= sync1 && !sync0;
					// Same-cycle syncs need no correction
					if (sync0 && sync1) begin
						delay0 <= '0;
						delay1 <= '0;
						state  <= DONE;
					end else if (sync0 || sync1) begin
						state <= MEASURE;
					end
				end

				MEASURE: begin
					if (other_sync) begin
						// Hold back the converter that led
						if (sync1_first) begin
							delay0 <= '0;
							delay1 <= cnt;
						end else begin
							delay0 <= cnt;
							delay1 <= '0;
						end
						state <= DONE;
					end else if (cnt == DLY_W'(MAX_DELAY)) begin
						// Offset beyond the delay line
						state <= ERROR;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				// Result held until the next resync
				DONE: begin
					state <= DONE;
				end

				ERROR: begin
					state <= ERROR;
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign sync_done  = (state == DONE);
	assign sync_error = (state == ERROR);

endmodule

`default_nettype wire

/* rtl/dual_adc_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_adc_interface import adc_pkg::*; #(
	parameter int MAX_DELAY = DEFAULT_MAX_DELAY
) (
	input  logic      adc_clk,
	input  logic      rst_n,
	input  logic      resync,
	input  adc_raw_t  raw0,
	input  adc_raw_t  raw1,
	output adc_word_t word0,
	output adc_word_t word1,
	output logic      user_sync0,
	output logic      user_sync1,
	output logic      user_outofrange0,
	output logic      user_outofrange1,
	output logic      sync_done,
	output logic      sync_error
);

	// Delay setting width follows the correctable range
	localparam int DLY_W = $clog2(MAX_DELAY + 1);

	logic [DLY_W-1:0] delay0;
	logic [DLY_W-1:0] delay1;
	adc_raw_t         raw0_dly;
	adc_raw_t         raw1_dly;

	// ==================================================
	// Alignment, watching syncs before the delay lines
	// ==================================================

	adc_align_fsm #(
		.MAX_DELAY (MAX_DELAY),
		.DLY_W     (DLY_W)
	) align_fsm (
		.adc_clk    (adc_clk),
		.rst_n      (rst_n),
		.resync     (resync),
		.sync0      (raw0.sync),
		.sync1      (raw1.sync),
		.delay0     (delay0),
		.delay1     (delay1),
		.sync_done  (sync_done),
		.sync_error (sync_error)
	);

	// ==================================================
	// Converter 0
	// ==================================================

	adc_delay_line #(
		.MAX_DELAY (MAX_DELAY),
		.DLY_W     (DLY_W)
	) dly0 (
		.adc_clk (adc_clk),
		.rst_n   (rst_n),
		.delay   (delay0),
		.din     (raw0),
		.dout    (raw0_dly)
	);

	adc_capture cap0 (
		.adc_clk         (adc_clk),
		.rst_n           (rst_n),
		.enable          (sync_done),
		.raw             (raw0_dly),
		.word            (word0),
		.user_sync       (user_sync0),
		.user_outofrange (user_outofrange0)
	);

	// ==================================================
	// Converter 1
	// ==================================================

	adc_delay_line #(
		.MAX_DELAY (MAX_DELAY),
		.DLY_W     (DLY_W)
	) dly1 (
		.adc_clk (adc_clk),
		.rst_n   (rst_n),
		.delay   (delay1),
		.din     (raw1),
		.dout    (raw1_dly)
	);

	adc_capture cap1 (
		.adc_clk         (adc_clk),
		.rst_n           (rst_n),
		.enable          (sync_done),
		.raw             (raw1_dly),
		.word            (word1),
		.user_sync       (user_sync1),
		.user_outofrange (user_outofrange1)
	);

endmodule

`default_nettype wire

/* tb/dual_adc_interface_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_adc_interface_chk #(
	// Set on the capture binding, clear on the aligner binding
	parameter bit CAPTURE = 1'b0
) (
	input logic adc_clk,
	input logic rst_n,
	input logic resync,
	input logic done_flag,
	input logic error_flag,
	input logic valid
);

	if (CAPTURE) begin : g_word
		// A word is only framed while both converters are aligned
		valid_needs_done: assert property (
			@(posedge adc_clk) disable iff (!rst_n) valid |-> $past(done_flag)
		) else $error("word valid without sync_done in its framing cycle");
	end else begin : g_flags
		flags_exclusive: assert property (
			@(posedge adc_clk) disable iff (!rst_n) !(done_flag && error_flag)
		) else $error("sync_done and sync_error high together");

		// Resync drops both flags on the next clock
		resync_clears: assert property (
			@(posedge adc_clk) disable iff (!rst_n) resync |=> (!done_flag && !error_flag)
		) else $error("alignment flag still high after resync");
	end

endmodule

// ==================================================
// Attach to the aligner and to each capture block
// ==================================================

bind adc_align_fsm dual_adc_interface_chk #(
	.CAPTURE (1'b0)
) fsm_chk (
	.adc_clk    (adc_clk),
	.rst_n      (rst_n),
	.resync     (resync),
	.done_flag  (sync_done),
	.error_flag (sync_error),
	.valid      (1'b0)
);

bind adc_capture dual_adc_interface_chk #(
	.CAPTURE (1'b1)
) cap_chk (
	.adc_clk    (adc_clk),
	.rst_n      (rst_n),
	.resync     (1'b0),
	.done_flag  (enable),
	.error_flag (1'b0),
	.valid      (word.valid)
);

`default_nettype wire

/* tb/dual_adc_interface_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_adc_interface_tb import adc_pkg::*; ();

	localparam int MAX_DELAY = DEFAULT_MAX_DELAY;
	// Pairs per stream, twelve sync groups
	localparam int NIDX      = 96;
	localparam int NWORDS    = NIDX / 2;
	// Idle pairs ahead of each stream
	localparam int LEAD      = 4;
	localparam int TIMEOUT   = 400;

	logic      adc_clk;
	logic      rst_n;
	logic      resync;
	adc_raw_t  raw0;
	adc_raw_t  raw1;
	adc_word_t word0;
	adc_word_t word1;
	logic      user_sync0;
	logic      user_sync1;
	logic      user_outofrange0;
	logic      user_outofrange1;
	logic      sync_done;
	logic      sync_error;

	adc_raw_t   seq0 [NIDX];
	adc_raw_t   seq1 [NIDX];
	adc_word_t  q0 [$];
	adc_word_t  q1 [$];
	// {user_sync, user_outofrange} seen with each valid word
	logic [1:0] flags0 [$];
	logic [1:0] flags1 [$];
	int         base0;
	int         base1;
	int         cyc;
	int         valid_cnt = 0;
	int         errors = 0;
	int         tests = 0;
	int         clean = 0;

	dual_adc_interface #(
		.MAX_DELAY (MAX_DELAY)
	) dual_adc_interface_i (
		.adc_clk          (adc_clk),
		.rst_n            (rst_n),
		.resync           (resync),
		.raw0             (raw0),
		.raw1             (raw1),
		.word0            (word0),
		.word1            (word1),
		.user_sync0       (user_sync0),
		.user_sync1       (user_sync1),
		.user_outofrange0 (user_outofrange0),
		.user_outofrange1 (user_outofrange1),
		.sync_done        (sync_done),
		.sync_error       (sync_error)
	);

	initial adc_clk = 1'b0;
	always #4 adc_clk = ~adc_clk;

	// ==================================================
	// Stimulus and reference model
	// ==================================================

	function automatic adc_raw_t rand_pair(input int idx);
		adc_raw_t p;
		p.even_i        = 8'($urandom);
		p.odd_i         = 8'($urandom);
		p.even_q        = 8'($urandom);
		p.odd_q         = 8'($urandom);
		p.sync          = (idx % 8 == 0);
		p.outofrange[0] = ($urandom % 5 == 0);
		p.outofrange[1] = ($urandom % 5 == 0);
		return p;
	endfunction

	function automatic adc_raw_t pair_at(input bit ch, input int idx);
		if (idx < 0 || idx >= NIDX) begin
			return '0;
		end
		return ch ? seq1[idx] : seq0[idx];
	endfunction

	// Word n is built from pairs 2n and 2n+1, oldest sample in slot 0
	function automatic adc_word_t expect_word(input bit ch, input int n);
		adc_raw_t  a;
		adc_raw_t  b;
		adc_word_t w;
		a = pair_at(ch, 2 * n);
		b = pair_at(ch, 2 * n + 1);
		w.datai[0]   = a.even_i;
		w.datai[1]   = a.odd_i;
		w.datai[2]   = b.even_i;
		w.datai[3]   = b.odd_i;
		w.dataq[0]   = a.even_q;
		w.dataq[1]   = a.odd_q;
		w.dataq[2]   = b.even_q;
		w.dataq[3]   = b.odd_q;
		w.sync       = a.sync;
		w.outofrange = {b.outofrange[1], b.outofrange[0], a.outofrange[1], a.outofrange[0]};
		w.valid      = 1'b1;
		return w;
	endfunction

	function automatic int rand_offset(input int lo, input int hi);
		int mag;
		mag = lo + int'($urandom % (hi - lo + 1));
		return (($urandom & 1) != 0) ? -mag : mag;
	endfunction

	task automatic mismatch(input string name, input logic [69:0] got, input logic [69:0] exp);
		errors++;
		$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic step();
		@(posedge adc_clk);
		#1;
		resync = 1'b0;
		raw0   = pair_at(1'b0, cyc - LEAD - base0);
		raw1   = pair_at(1'b1, cyc - LEAD - base1);
		cyc++;
	endtask

	// Word and its user flags against the model
	task automatic compare_word(input bit ch, input int n);
		adc_word_t  exp;
		adc_word_t  got;
		logic [1:0] flags;
		exp   = expect_word(ch, n);
		got   = ch ? q1[n] : q0[n];
		flags = ch ? flags1[n] : flags0[n];
		if (got !== exp) begin
			mismatch($sformatf("word%0d #%0d", ch, n), got, exp);
		end
		if (flags[1] !== exp.sync) begin
			mismatch($sformatf("user_sync%0d #%0d", ch, n), flags[1], exp.sync);
		end
		if (flags[0] !== |exp.outofrange) begin
			mismatch($sformatf("user_outofrange%0d #%0d", ch, n), flags[0], |exp.outofrange);
		end
	endtask

	// ==================================================
	// Output monitor
	// ==================================================

	always @(negedge adc_clk) begin
		if (rst_n && (word0.valid || word1.valid)) begin
			valid_cnt++;
			if (!sync_done) begin
				errors++;
				$display("ERROR at %0t: a word was valid while sync_done was low", $time);
			end
			if (word0.valid) begin
				q0.push_back(word0);
				flags0.push_back({user_sync0, user_outofrange0});
			end
			if (word1.valid) begin
				q1.push_back(word1);
				flags1.push_back({user_sync1, user_outofrange1});
			end
		end
	end

	// ==================================================
	// Test sequencing
	// ==================================================

	task automatic finish_run();
		$display("summary: %0d tests, %0d clean, %0d with errors, %0d errors in all",
			tests, clean, tests - clean, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	// Positive k makes converter 1 trail converter 0
	task automatic restart(input int k);
		base0 = (k < 0) ? -k : 0;
		base1 = (k > 0) ? k : 0;
		for (int i = 0; i < NIDX; i++) begin
			seq0[i] = rand_pair(i);
			seq1[i] = rand_pair(i);
		end
		cyc = 0;
		@(posedge adc_clk);
		#1;
		resync = 1'b1;
		raw0   = '0;
		raw1   = '0;
		step();
		if (sync_done !== 1'b0) begin
			mismatch("sync_done", sync_done, 1'b0);
		end
		if (sync_error !== 1'b0) begin
			mismatch("sync_error", sync_error, 1'b0);
		end
		q0.delete();
		q1.delete();
		flags0.delete();
		flags1.delete();
		valid_cnt = 0;
	endtask

	task automatic wait_flags();
		int n;
		n = 0;
		while (!sync_done && !sync_error) begin
			step();
			n++;
			if (n > TIMEOUT) begin
				errors++;
				$display("ERROR at %0t: neither sync_done nor sync_error rose", $time);
				finish_run();
			end
		end
	endtask

	task automatic wait_words(input int count);
		int n;
		n = 0;
		while (q0.size() < count || q1.size() < count) begin
			step();
			n++;
			if (n > TIMEOUT) begin
				errors++;
				$display("ERROR at %0t: only %0d and %0d words arrived, %0d expected",
					$time, q0.size(), q1.size(), count);
				finish_run();
			end
		end
	endtask

	task automatic end_test(input string name, input int k, input int start);
		tests++;
		if (errors == start) begin
			clean++;
			$display("test %0d %s (offset %0d): ok", tests, name, k);
		end else begin
			$display("test %0d %s (offset %0d): %0d errors", tests, name, k, errors - start);
		end
	endtask

	task automatic run_align(input int k, input string name);
		int start;
		start = errors;
		restart(k);
		wait_flags();
		if (sync_done !== 1'b1) begin
			mismatch("sync_done", sync_done, 1'b1);
		end else begin
			if (valid_cnt != 0) begin
				errors++;
				$display("ERROR at %0t: a word appeared before sync_done", $time);
			end
			wait_words(NWORDS);
			for (int n = 0; n < NWORDS; n++) begin
				compare_word(1'b0, n);
				compare_word(1'b1, n);
			end
		end
		if (sync_error !== 1'b0) begin
			mismatch("sync_error", sync_error, 1'b0);
		end
		end_test(name, k, start);
	endtask

	task automatic run_error(input int k, input string name);
		int start;
		start = errors;
		restart(k);
		wait_flags();
		if (sync_error !== 1'b1) begin
			mismatch("sync_error", sync_error, 1'b1);
		end
		// Watch a few sync periods for stray words
		repeat (32) begin
			step();
			if (sync_done !== 1'b0) begin
				mismatch("sync_done", sync_done, 1'b0);
			end
		end
		if (valid_cnt != 0) begin
			errors++;
			$display("ERROR at %0t: %0d words appeared after a failed alignment", $time, valid_cnt);
		end
		end_test(name, k, start);
	endtask

	initial begin
		void'($urandom(32'hd6195c5d));
		rst_n  = 1'b0;
		resync = 1'b0;
		raw0   = '0;
		raw1   = '0;
		cyc    = 0;
		base0  = 0;
		base1  = 0;
		repeat (4) @(posedge adc_clk);
		#1;
		rst_n = 1'b1;
		run_align(rand_offset(0, MAX_DELAY), "align after reset");
		run_align(MAX_DELAY, "converter 1 trails by the largest offset");
		run_align(-MAX_DELAY, "converter 0 trails by the largest offset");
		run_error(rand_offset(MAX_DELAY + 1, MAX_DELAY + 4), "offset beyond range");
		run_align(rand_offset(0, MAX_DELAY), "realign after resync");
		run_align(0, "syncs in the same cycle");
		finish_run();
	end

endmodule

`default_nettype wire

/* verilog.f */
rtl/adc_pkg.sv
rtl/adc_delay_line.sv
rtl/adc_capture.sv
rtl/adc_align_fsm.sv
rtl/dual_adc_interface.sv
tb/dual_adc_interface_chk.sv
tb/dual_adc_interface_tb.sv
